//--- common/switch_pkg.sv
/*
  Shared constants of the four port switch
  Port count, word widths, delay depths and retry buffer sizing
*/
package switch_pkg;

  // Port count and port index width
  localparam int ports = 4;
  localparam int port_w = 2;

  // Payload width of a single word packet
  localparam int data_w = 32;

  // Time of flight from the input pins to the allocator
  localparam int link_delay_cycles = 2;

  // Serialization delay after the crossbar register
  localparam int serial_delay_cycles = 2;

  // Retry buffer entries per input and the matching pointer width
  localparam int buf_depth = 4;
  localparam int buf_ptr_w = 2;

  // Uncontended latency, time of flight plus crossbar register plus serialization
  localparam int switch_latency = link_delay_cycles + 1 + serial_delay_cycles;

endpackage

//--- hdl/link_delay.sv
/*
  Valid and word shift register of fixed depth
  Models link time of flight and output serialization
*/
`timescale 1ns/1ps

module link_delay
  import switch_pkg::*;
#(
  parameter int depth = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  logic [data_w+port_w-1:0] in_word,
  output logic                     out_valid,
  output logic [data_w+port_w-1:0] out_word
);

  logic [depth-1:0]                     valid_q;
  logic [depth-1:0][data_w+port_w-1:0] word_q;

  // Valid bits are cleared so nothing leaves the line after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int s = 1; s < depth; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    word_q[0] <= in_word;
    for (int s = 1; s < depth; s++) begin
      word_q[s] <= word_q[s-1];
    end
  end

  assign out_valid = valid_q[depth-1];
  assign out_word  = word_q[depth-1];

endmodule

//--- switch/switch_alloc.sv
/*
  Per output round-robin allocator
  Buffered heads win over fresh packets, pop strobes per input
*/
`timescale 1ns/1ps

module switch_alloc
  import switch_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [ports-1:0]                 lnk_valid,
  input  logic [ports-1:0][port_w-1:0]     lnk_dest,
  input  logic [ports-1:0]                 buf_valid,
  input  logic [ports-1:0][port_w-1:0]     buf_dest,
  output logic [ports-1:0][ports-1:0]      grant_fresh,
  output logic [ports-1:0][ports-1:0]      grant_buf,
  output logic [ports-1:0]                 pop
);

  // One pointer per output, rows of the request matrices are outputs
  logic [ports-1:0][port_w-1:0] ptr_q;
  logic [ports-1:0][ports-1:0]  buf_req;
  logic [ports-1:0][ports-1:0]  fresh_req;

  // First requester at or after the start index, one hot
  function automatic logic [ports-1:0] rr_pick(input logic [ports-1:0]  req,
                                               input logic [port_w-1:0] start);
    logic [ports-1:0]  onehot;
    logic [port_w-1:0] idx;
    logic              found;
    onehot = '0;
    found  = 1'b0;
    for (int k = 0; k < ports; k++) begin
      // Index wraps naturally at the port count
      idx = start + port_w'(k);
      if (!found && req[idx]) begin
        onehot[idx] = 1'b1;
        found       = 1'b1;
      end
    end
    return onehot;
  endfunction

  function automatic logic [port_w-1:0] onehot_index(input logic [ports-1:0] onehot);
    logic [port_w-1:0] idx;
    idx = '0;
    for (int k = 0; k < ports; k++) begin
      if (onehot[k]) begin
        idx = port_w'(k);
      end
    end
    return idx;
  endfunction

  always_comb begin
    for (int o = 0; o < ports; o++) begin
      for (int i = 0; i < ports; i++) begin
        buf_req[o][i]   = buf_valid[i] && (buf_dest[i] == port_w'(o));
        fresh_req[o][i] = lnk_valid[i] && (lnk_dest[i] == port_w'(o));
      end
    end
  end

  always_comb begin
    for (int o = 0; o < ports; o++) begin
      grant_buf[o] = rr_pick(buf_req[o], ptr_q[o]);
      // Fresh traffic only gets the output when no buffered head wants it
      if (|buf_req[o]) begin
        grant_fresh[o] = '0;
      end else begin
        grant_fresh[o] = rr_pick(fresh_req[o], ptr_q[o]);
      end
    end
  end

  // Column OR of the buffered grants
  always_comb begin
    pop = '0;
    for (int o = 0; o < ports; o++) begin
      pop = pop | grant_buf[o];
    end
  end

  // Only fresh grants advance the pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else begin
      for (int o = 0; o < ports; o++) begin
        if (|grant_fresh[o]) begin
          ptr_q[o] <= onehot_index(grant_fresh[o]) + port_w'(1);
        end
      end
    end
  end

endmodule

//--- switch/photonic_switch.sv
/*
  Registered crossbar
  Forwards granted packets and diverts fresh losers toward the retry buffers
*/
`timescale 1ns/1ps

module photonic_switch
  import switch_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [ports-1:0]                 lnk_valid,
  input  logic [ports-1:0][port_w-1:0]     lnk_dest,
  input  logic [ports-1:0][data_w-1:0]     lnk_data,
  input  logic [ports-1:0][data_w-1:0]     buf_data,
  input  logic [ports-1:0][ports-1:0]      grant_fresh,
  input  logic [ports-1:0][ports-1:0]      grant_buf,
  output logic [ports-1:0]                 sw_valid,
  output logic [ports-1:0][data_w-1:0]     sw_data,
  output logic [ports-1:0]                 sw_retry,
  output logic [ports-1:0]                 divert_valid,
  output logic [ports-1:0][port_w-1:0]     divert_dest,
  output logic [ports-1:0][data_w-1:0]     divert_data
);

  logic [ports-1:0]             xbar_valid;
  logic [ports-1:0][data_w-1:0] xbar_data;
  logic [ports-1:0]             xbar_retry;
  logic [ports-1:0]             lost;

  // Grant rows are one hot, so an OR of the masked sources is the mux
  always_comb begin
    for (int o = 0; o < ports; o++) begin
      xbar_valid[o] = (|grant_fresh[o]) || (|grant_buf[o]);
      xbar_retry[o] = |grant_buf[o];
      xbar_data[o]  = '0;
      for (int i = 0; i < ports; i++) begin
        if (grant_fresh[o][i]) begin
          xbar_data[o] = xbar_data[o] | lnk_data[i];
        end
        if (grant_buf[o][i]) begin
          xbar_data[o] = xbar_data[o] | buf_data[i];
        end
      end
    end
  end

  // A fresh packet lost when its own row did not grant its input
  always_comb begin
    for (int i = 0; i < ports; i++) begin
      lost[i] = lnk_valid[i] && !grant_fresh[lnk_dest[i]][i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sw_valid     <= '0;
      sw_retry     <= '0;
      divert_valid <= '0;
    end else begin
      sw_valid     <= xbar_valid;
      sw_retry     <= xbar_retry;
      divert_valid <= lost;
    end
  end

  // Payload side of the crossbar and the divert path
  always_ff @(posedge clk) begin
    sw_data     <= xbar_data;
    divert_dest <= lnk_dest;
    divert_data <= lnk_data;
  end

endmodule

//--- switch/retry_buffer.sv
/*
  Retry FIFO for one input
  Head view with bypass when empty, pop on grant, drop when full
*/
`timescale 1ns/1ps

module retry_buffer
  import switch_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              divert_valid,
  input  logic [port_w-1:0] divert_dest,
  input  logic [data_w-1:0] divert_data,
  input  logic              pop,
  output logic              buf_valid,
  output logic [port_w-1:0] buf_dest,
  output logic [data_w-1:0] buf_data,
  output logic              drop
);

  logic [buf_depth-1:0][port_w-1:0] mem_dest;
  logic [buf_depth-1:0][data_w-1:0] mem_data;
  logic [buf_ptr_w-1:0]             wr_ptr_q;
  logic [buf_ptr_w-1:0]             rd_ptr_q;
  logic [buf_ptr_w:0]               count_q;
  logic                             empty;
  logic                             full;
  logic                             wr_en;
  logic                             rd_en;

  assign empty = (count_q == '0);
  assign full  = (count_q == (buf_ptr_w+1)'(buf_depth));

  // New diversion is visible in its own cycle when nothing is queued ahead of it
  assign buf_valid = !empty || divert_valid;
  assign buf_dest  = empty ? divert_dest : mem_dest[rd_ptr_q];
  assign buf_data  = empty ? divert_data : mem_data[rd_ptr_q];

  // A bypassed word that is popped at once never enters storage
  // Pop on a full FIFO frees the slot for the incoming word
  assign wr_en = divert_valid && !(empty && pop) && (!full || pop);
  assign rd_en = pop && !empty;
  assign drop  = divert_valid && full && !pop;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + buf_ptr_w'(1);
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + buf_ptr_w'(1);
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + (buf_ptr_w+1)'(1);
        2'b01:   count_q <= count_q - (buf_ptr_w+1)'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_dest[wr_ptr_q] <= divert_dest;
      mem_data[wr_ptr_q] <= divert_data;
    end
  end

endmodule

//--- hdl/switch_top.sv
/*
  Switch node top level
  Input delay lines, allocator, crossbar, retry buffers, output delay lines
*/
`timescale 1ns/1ps

module switch_top
  import switch_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [ports-1:0]                 in_valid,
  input  logic [ports-1:0][port_w-1:0]     in_dest,
  input  logic [ports-1:0][data_w-1:0]     in_data,
  output logic [ports-1:0]                 out_valid,
  output logic [ports-1:0][data_w-1:0]     out_data,
  output logic [ports-1:0]                 out_retry,
  output logic [ports-1:0]                 drop
);

  // Link side
  logic [ports-1:0]                     lnk_valid;
  logic [ports-1:0][port_w-1:0]         lnk_dest;
  logic [ports-1:0][data_w-1:0]         lnk_data;
  logic [ports-1:0][data_w+port_w-1:0]  lnk_word;

  // Retry buffer heads
  logic [ports-1:0]                     buf_valid;
  logic [ports-1:0][port_w-1:0]         buf_dest;
  logic [ports-1:0][data_w-1:0]         buf_data;
  logic [ports-1:0]                     pop;

  logic [ports-1:0][ports-1:0]          grant_fresh;
  logic [ports-1:0][ports-1:0]          grant_buf;

  // Crossbar results and diversions
  logic [ports-1:0]                     sw_valid;
  logic [ports-1:0][data_w-1:0]         sw_data;
  logic [ports-1:0]                     sw_retry;
  logic [ports-1:0]                     divert_valid;
  logic [ports-1:0][port_w-1:0]         divert_dest;
  logic [ports-1:0][data_w-1:0]         divert_data;

  logic [ports-1:0][data_w+port_w-1:0]  ser_word;

  for (genvar p = 0; p < ports; p++) begin : g_port
    link_delay #(.depth(link_delay_cycles)) i_link_delay (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid[p]),
      .in_word   ({in_dest[p], in_data[p]}),
      .out_valid (lnk_valid[p]),
      .out_word  (lnk_word[p])
    );

    assign lnk_dest[p] = lnk_word[p][data_w +: port_w];
    assign lnk_data[p] = lnk_word[p][data_w-1:0];

    retry_buffer i_retry_buffer (
      .clk          (clk),
      .rst_n        (rst_n),
      .divert_valid (divert_valid[p]),
      .divert_dest  (divert_dest[p]),
      .divert_data  (divert_data[p]),
      .pop          (pop[p]),
      .buf_valid    (buf_valid[p]),
      .buf_dest     (buf_dest[p]),
      .buf_data     (buf_data[p]),
      .drop         (drop[p])
    );

    // Output port is fixed by the row, the spare bits carry the retry mark
    link_delay #(.depth(serial_delay_cycles)) i_serial_delay (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (sw_valid[p]),
      .in_word   ({{(port_w-1){1'b0}}, sw_retry[p], sw_data[p]}),
      .out_valid (out_valid[p]),
      .out_word  (ser_word[p])
    );

    assign out_data[p]  = ser_word[p][data_w-1:0];
    assign out_retry[p] = out_valid[p] & ser_word[p][data_w];
  end

  switch_alloc i_switch_alloc (
    .clk         (clk),
    .rst_n       (rst_n),
    .lnk_valid   (lnk_valid),
    .lnk_dest    (lnk_dest),
    .buf_valid   (buf_valid),
    .buf_dest    (buf_dest),
    .grant_fresh (grant_fresh),
    .grant_buf   (grant_buf),
    .pop         (pop)
  );

  photonic_switch i_photonic_switch (
    .clk          (clk),
    .rst_n        (rst_n),
    .lnk_valid    (lnk_valid),
    .lnk_dest     (lnk_dest),
    .lnk_data     (lnk_data),
    .buf_data     (buf_data),
    .grant_fresh  (grant_fresh),
    .grant_buf    (grant_buf),
    .sw_valid     (sw_valid),
    .sw_data      (sw_data),
    .sw_retry     (sw_retry),
    .divert_valid (divert_valid),
    .divert_dest  (divert_dest),
    .divert_data  (divert_data)
  );

endmodule

//--- testbench/tb_clock.sv
/*
  Free running testbench clock with a 40 ns period
*/
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #20;
      clk = ~clk;
    end
  end

endmodule

//--- testbench/switch_assert.sv
/*
  Concurrent checks on allocator grants and retry buffer drops
  Bound into switch_alloc and into every retry_buffer
*/
`timescale 1ns/1ps

module switch_assert
  import switch_pkg::*;
(
  input logic                        clk,
  input logic                        rst_n,
  input logic [ports-1:0][ports-1:0] grant_fresh,
  input logic [ports-1:0][ports-1:0] grant_buf,
  input logic                        divert_valid,
  input logic                        pop,
  input logic                        drop
);

  logic [ports-1:0][ports-1:0] grant_any;
  logic [ports-1:0][ports-1:0] fresh_col;
  logic [ports-1:0][ports-1:0] buf_col;
  int                          occ_q;

  // Column views with one row per source input
  always_comb begin
    for (int o = 0; o < ports; o++) begin
      for (int i = 0; i < ports; i++) begin
        grant_any[o][i] = grant_fresh[o][i] | grant_buf[o][i];
        fresh_col[i][o] = grant_fresh[o][i];
        buf_col[i][o]   = grant_buf[o][i];
      end
    end
  end

  // Buffer occupancy seen from the port events alone
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occ_q <= 0;
    end else begin
      occ_q <= occ_q + int'(divert_valid && !drop) - int'(pop);
    end
  end

  for (genvar g = 0; g < ports; g++) begin : g_chk
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant_any[g]))
      else $error("output %0d granted to more than one source", g);
    assert property (@(posedge clk) disable iff (!rst_n)
                     $onehot0(fresh_col[g]) && $onehot0(buf_col[g]))
      else $error("input %0d granted on more than one output", g);
  end

  assert property (@(posedge clk) disable iff (!rst_n) drop |-> (occ_q == buf_depth))
    else $error("drop pulse while the retry buffer is not full");

endmodule

bind switch_alloc switch_assert i_alloc_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .grant_fresh  (grant_fresh),
  .grant_buf    (grant_buf),
  .divert_valid (1'b0),
  .pop          (1'b0),
  .drop         (1'b0)
);

bind retry_buffer switch_assert i_buffer_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .grant_fresh  ('0),
  .grant_buf    ('0),
  .divert_valid (divert_valid),
  .pop          (pop),
  .drop         (drop)
);

//--- testbench/switch_tb.sv
/*
  Switch node testbench
  Stimulus table, xorshift overload traffic, scoreboard, compare tasks and watchdog
*/
`timescale 1ns/1ps

module switch_tb
  import switch_pkg::*;
();

  localparam int reset_cycles = 10;
  localparam int rand_cycles  = 48;
  localparam int hot_dest     = 1;

  logic                         clk;
  logic                         rst_n;
  logic [ports-1:0]             in_valid;
  logic [ports-1:0][port_w-1:0] in_dest;
  logic [ports-1:0][data_w-1:0] in_data;
  logic [ports-1:0]             out_valid;
  logic [ports-1:0][data_w-1:0] out_data;
  logic [ports-1:0]             out_retry;
  logic [ports-1:0]             drop;

  int          cyc;
  int          quiet_end;
  bit          random_phase;
  int          sent_count;
  int          delivered_count;
  int          drop_count;
  logic [31:0] rnd;

  // Stimulus table with one row per packet in cycle offset order
  int                row_off[$];
  int                row_port[$];
  int                row_dest[$];
  logic [data_w-1:0] row_data[$];
  int                row_retry[$];

  // Words in flight
  // A retry of -1 leaves the mark to follow from the latency
  int                sb_dest[$];
  logic [data_w-1:0] sb_data[$];
  int                sb_sent[$];
  int                sb_retry[$];

  tb_clock i_tb_clock (.clk(clk));

  switch_top i_switch_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_dest   (in_dest),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_retry (out_retry),
    .drop      (drop)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(input string what, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("** Error at %0t: %s expected %h, got %h",
                               $time, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("** Error at %0t: %s expected %b, got %b",
                               $time, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      report_failure($sformatf("** Error at %0t: %s expected %0d, got %0d",
                               $time, what, exp, act));
    end
  endtask

  task automatic add_row(input int off, input int port, input int dest,
                         input logic [data_w-1:0] data, input int retry);
    row_off.push_back(off);
    row_port.push_back(port);
    row_dest.push_back(dest);
    row_data.push_back(data);
    row_retry.push_back(retry);
  endtask

  task automatic build_table();
    // Uncontended sweep
    // Port 3 is the last winner everywhere so all pointers return to 0
    for (int p = 0; p < ports; p++) begin
      for (int d = 0; d < ports; d++) begin
        add_row(p * ports + d, p, d, 32'hc0de_0000 + 32'(p * 16 + d), 0);
      end
    end
    // Collision on output 2 where the lower input wins with the pointer at 0
    add_row(24, 0, 2, 32'ha5a5_0001, 0);
    add_row(24, 1, 2, 32'ha5a5_0002, 1);
    // Repeated collisions on output 0
    // Fresh winner alternates between inputs 1 and 3
    add_row(32, 1, 0, 32'h3c3c_0010, 0);
    add_row(32, 3, 0, 32'h3c3c_0030, 1);
    add_row(36, 1, 0, 32'h3c3c_0011, 1);
    add_row(36, 3, 0, 32'h3c3c_0031, 0);
    add_row(40, 1, 0, 32'h3c3c_0012, 0);
    add_row(40, 3, 0, 32'h3c3c_0032, 1);
    add_row(44, 1, 0, 32'h3c3c_0013, 1);
    add_row(44, 3, 0, 32'h3c3c_0033, 0);
  endtask

  task automatic send(input int port, input int dest, input logic [data_w-1:0] data,
                      input int retry);
    in_valid[port] = 1'b1;
    in_dest[port]  = port_w'(dest);
    in_data[port]  = data;
    sb_dest.push_back(dest);
    sb_data.push_back(data);
    sb_sent.push_back(cyc);
    sb_retry.push_back(retry);
    sent_count++;
  endtask

  // Idle inputs until every word left is accounted for as a drop
  task automatic drain();
    int w;
    @(posedge clk);
    #1;
    in_valid = '0;
    w = 0;
    while (sb_data.size() != drop_count && w < 400) begin
      @(posedge clk);
      w++;
    end
    repeat (12) @(posedge clk);
  endtask

  task automatic match_delivery(input int p);
    int idx;
    int lat;
    idx = -1;
    // A word from the table that is due now on this output
    for (int k = 0; k < sb_data.size(); k++) begin
      if (idx < 0 && sb_dest[k] == p && sb_retry[k] == 0 &&
          sb_sent[k] + switch_latency == cyc) begin
        idx = k;
      end
    end
    if (idx >= 0) begin
      check_word($sformatf("data on output %0d", p), sb_data[idx], out_data[p]);
    end else begin
      for (int k = 0; k < sb_data.size(); k++) begin
        if (idx < 0 && sb_dest[k] == p && sb_data[k] === out_data[p]) begin
          idx = k;
        end
      end
    end
    if (idx < 0) begin
      report_failure($sformatf(
        "Output %0d delivered %h, which was never sent there or was already delivered",
        p, out_data[p]));
    end else begin
      lat = cyc - sb_sent[idx];
      check_flag("arrival no earlier than the switch latency", 1'b1, lat >= switch_latency);
      check_flag($sformatf("out_retry[%0d] after %0d cycles", p, lat),
                 lat > switch_latency, out_retry[p]);
      if (sb_retry[idx] == 0) begin
        check_count($sformatf("latency of %h", sb_data[idx]), switch_latency, lat);
      end else if (sb_retry[idx] == 1) begin
        check_flag($sformatf("out_retry[%0d] of %h", p, sb_data[idx]), 1'b1, out_retry[p]);
      end
      sb_dest.delete(idx);
      sb_data.delete(idx);
      sb_sent.delete(idx);
      sb_retry.delete(idx);
      delivered_count++;
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < ports; p++) begin
        if (cyc < quiet_end) begin
          check_flag($sformatf("out_valid[%0d] before the first arrival", p), 1'b0, out_valid[p]);
        end
        if (!out_valid[p]) begin
          check_flag($sformatf("out_retry[%0d] while idle", p), 1'b0, out_retry[p]);
        end
        if (!random_phase) begin
          check_flag($sformatf("drop[%0d] under light traffic", p), 1'b0, drop[p]);
        end
        if (drop[p]) begin
          drop_count++;
        end
        if (out_valid[p]) begin
          match_delivery(p);
        end
      end
    end
  end

  initial begin
    int r;
    int c;
    in_valid     = '0;
    in_dest      = '0;
    in_data      = '0;
    rst_n        = 1'b0;
    quiet_end    = 32'h7fff_ffff;
    random_phase = 1'b0;
    rnd          = 32'h8ba7;
    build_table();
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n     = 1'b1;
    quiet_end = cyc + 1 + switch_latency;
    r = 0;
    for (c = 0; r < row_off.size(); c++) begin
      @(posedge clk);
      #1;
      in_valid = '0;
      while (r < row_off.size() && row_off[r] == c) begin
        send(row_port[r], row_dest[r], row_data[r], row_retry[r]);
        r++;
      end
    end
    drain();
    check_count("table words still in flight", 0, sb_data.size());

    // Overload of one output from every port
    random_phase = 1'b1;
    for (c = 0; c < rand_cycles; c++) begin
      @(posedge clk);
      #1;
      in_valid = '0;
      for (int p = 0; p < ports; p++) begin
        rnd = xorshift(rnd);
        if (rnd[1:0] != 2'b00) begin
          send(p, hot_dest, {rnd[31:16], 16'(sent_count)}, -1);
        end
      end
    end
    drain();
    // Every word sent is either delivered once or dropped
    if (sent_count != delivered_count + drop_count) begin
      report_failure($sformatf("** Error at %0t: %s expected %0d, got %0d", $time,
                               "words delivered plus drop pulses", sent_count,
                               delivered_count + drop_count));
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

  initial begin
    int limit;
    @(posedge clk);
    limit = reset_cycles + 40 * row_off.size() + 20 * rand_cycles * ports;
    repeat (limit) @(posedge clk);
    report_failure($sformatf("Timeout: the run did not finish within %0d cycles", limit));
  end

endmodule

//--- flist.f
common/switch_pkg.sv
hdl/link_delay.sv
switch/switch_alloc.sv
switch/photonic_switch.sv
switch/retry_buffer.sv
hdl/switch_top.sv
testbench/tb_clock.sv
testbench/switch_assert.sv
testbench/switch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the switch testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module switch_tb -f flist.f -o switch_sim

# A failing check ends the simulation with a nonzero status
./obj_dir/switch_sim
